//--- source/tl_mem_pkg.sv
/*
 * Shared constants, types and encodings for the TileLink-UL memory slave.
 * Referenced by scoped name from the RTL and the testbench.
 */
package tl_mem_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int XLEN           = 32;    // Bus data width
    localparam int MEM_BYTES      = 1024;  // Byte array depth
    localparam int MEM_ADDR_WIDTH = 10;    // Byte index into the array
    localparam int SID_WIDTH      = 2;     // Source ID width
    localparam int MAX_SIZE       = 2;     // Word, the largest legal size code

    ////////////////////////////////////////////////////////////
    // Bus field types
    ////////////////////////////////////////////////////////////

    typedef logic [XLEN-1:0]      data_t;     // Data word, little-endian lanes
    typedef logic [XLEN-1:0]      addr_t;     // Full byte address
    typedef logic [XLEN/8-1:0]    mask_t;     // One bit per byte lane
    typedef logic [2:0]           size_t;     // log2 of the byte count
    typedef logic [SID_WIDTH-1:0] source_t;
    typedef logic [2:0]           opcode_t;
    typedef logic [1:0]           d_param_t;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////

    // A channel
    localparam opcode_t OP_PUT_FULL_DATA = 3'd0;
    localparam opcode_t OP_GET           = 3'd4;

    // D channel
    localparam opcode_t OP_ACCESS_ACK       = 3'd0;  // Write done
    localparam opcode_t OP_ACCESS_ACK_DATA  = 3'd2;  // Read data follows
    localparam opcode_t OP_ACCESS_ACK_ERROR = 3'd7;  // Denied request

    // Response params
    localparam d_param_t PARAM_OK    = 2'd0;
    localparam d_param_t PARAM_ERROR = 2'd2;

endpackage

//--- source/tl_access_check.sv
/*
 * Legality check for the request on the A channel, purely combinational.
 * The controller samples denied at the acceptance edge.
 */
`timescale 1ns/1ps

module tl_access_check (
    input  tl_mem_pkg::opcode_t opcode,
    input  tl_mem_pkg::size_t   size,
    input  tl_mem_pkg::addr_t   address,
    input  tl_mem_pkg::mask_t   mask,
    output logic                denied
);

    logic                       is_write;
    logic                       opcode_ok;
    logic                       size_ok;
    logic                       range_ok;
    logic                       mask_ok;
    logic [tl_mem_pkg::XLEN:0]  span;       // Bytes moved, one bit wider than the bus
    logic [tl_mem_pkg::XLEN:0]  last_byte;  // Extra bit keeps top addresses from wrapping

    ////////////////////////////////////////////////////////////
    // Opcode and size
    ////////////////////////////////////////////////////////////

    assign is_write  = (opcode == tl_mem_pkg::OP_PUT_FULL_DATA);
    assign opcode_ok = is_write || (opcode == tl_mem_pkg::OP_GET);
    assign size_ok   = (size <= tl_mem_pkg::MAX_SIZE);

    ////////////////////////////////////////////////////////////
    // Address range
    ////////////////////////////////////////////////////////////

    // Full address counts, so any upper bit set lands past the end
    always_comb begin
        span      = 1 << size;
        last_byte = {1'b0, address} + span - 1;
        range_ok  = (last_byte < tl_mem_pkg::MEM_BYTES);
    end

    ////////////////////////////////////////////////////////////
    // Write mask
    ////////////////////////////////////////////////////////////

    // Aligned group of exactly 2^size ones, anywhere on the bus
    always_comb begin
        case (size)
            3'd0:    mask_ok = $onehot(mask);                      // Any single lane
            3'd1:    mask_ok = (mask == 4'b0011) || (mask == 4'b1100);
            3'd2:    mask_ok = (mask == 4'b1111);                  // Full word
            default: mask_ok = 1'b0;                               // Caught by size check too
        endcase
    end

    // Reads ignore the mask
    assign denied = !opcode_ok || !size_ok || !range_ok || (is_write && !mask_ok);

endmodule

//--- source/byte_sequencer.sv
/*
 * Byte-wide memory array with a part counter that moves one byte per cycle.
 * A start pulse runs 2^size bytes from addr; done pulses after the last one.
 */
`timescale 1ns/1ps

module byte_sequencer (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   start,  // One-cycle pulse
    input  logic                                   write,  // High for PUT, low for GET
    input  logic [tl_mem_pkg::MEM_ADDR_WIDTH-1:0]  addr,   // Held by the controller
    input  tl_mem_pkg::size_t                      size,
    input  tl_mem_pkg::data_t                      wdata,  // Low lanes carry the bytes
    output logic                                   done,
    output tl_mem_pkg::data_t                      rdata
);

    logic [7:0]                              mem [tl_mem_pkg::MEM_BYTES];
    logic                                    busy;
    logic [1:0]                              part;       // Byte index within the access
    logic [1:0]                              last_part;
    logic [tl_mem_pkg::MEM_ADDR_WIDTH-1:0]   byte_addr;

    ////////////////////////////////////////////////////////////
    // Part counter
    ////////////////////////////////////////////////////////////

    // Index of the final byte for this size
    always_comb begin
        case (size)
            3'd0:    last_part = 2'd0;
            3'd1:    last_part = 2'd1;
            default: last_part = 2'd3;  // Word, larger sizes never start
        endcase
    end

    assign byte_addr = addr + {{(tl_mem_pkg::MEM_ADDR_WIDTH-2){1'b0}}, part};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            part <= 2'd0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;                  // Pulse only
            if (start) begin
                busy <= 1'b1;
                part <= 2'd0;
            end else if (busy) begin
                part <= part + 2'd1;
                if (part == last_part) begin
                    busy <= 1'b0;
                    part <= 2'd0;
                    done <= 1'b1;          // Lands 2^size cycles after start
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Array and read assembly
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            rdata <= '0;                   // Unused lanes read back as zero
        end else if (busy) begin
            if (write) begin
                mem[byte_addr] <= wdata[8*part +: 8];
            end else begin
                rdata[8*part +: 8] <= mem[byte_addr];  // Little-endian lane
            end
        end
    end

    // Controller must wait for done before the next access
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy);

endmodule

//--- source/tl_mem_ctrl.sv
/*
 * Request capture, access FSM and D-channel response registers.
 * Takes one request at a time and holds the response until tl_d_ready.
 */
`timescale 1ns/1ps

module tl_mem_ctrl (
    input  logic                                   clk,
    input  logic                                   reset,

    // A channel
    input  logic                                   tl_a_valid,
    output logic                                   tl_a_ready,
    input  tl_mem_pkg::opcode_t                    tl_a_opcode,
    input  tl_mem_pkg::size_t                      tl_a_size,
    input  tl_mem_pkg::source_t                    tl_a_source,
    input  tl_mem_pkg::addr_t                      tl_a_address,
    input  tl_mem_pkg::data_t                      tl_a_data,

    // D channel
    output logic                                   tl_d_valid,
    input  logic                                   tl_d_ready,
    output tl_mem_pkg::opcode_t                    tl_d_opcode,
    output tl_mem_pkg::d_param_t                   tl_d_param,
    output tl_mem_pkg::size_t                      tl_d_size,
    output tl_mem_pkg::source_t                    tl_d_source,
    output tl_mem_pkg::data_t                      tl_d_data,
    output logic                                   tl_d_denied,

    // Access check result for the live A fields
    input  logic                                   denied,

    // Byte sequencer
    output logic                                   seq_start,
    output logic                                   seq_write,
    output logic [tl_mem_pkg::MEM_ADDR_WIDTH-1:0]  seq_addr,
    output tl_mem_pkg::size_t                      seq_size,
    output tl_mem_pkg::data_t                      seq_wdata,
    input  logic                                   seq_done,
    input  tl_mem_pkg::data_t                      seq_rdata
);

    typedef enum logic [1:0] {
        IDLE,          // Waiting for a request
        ACCESS,        // Sequencer running, or one dead cycle when denied
        RESPOND,       // Denied path loads the error response here
        RESPOND_WAIT   // Response on the bus, waiting for tl_d_ready
    } state_t;

    state_t                 state;
    logic                   accept;
    logic                   load_resp;
    logic                   req_denied;
    tl_mem_pkg::source_t    req_source;
    tl_mem_pkg::opcode_t    resp_opcode;
    tl_mem_pkg::d_param_t   resp_param;
    tl_mem_pkg::data_t      resp_data;

    assign accept = tl_a_valid && tl_a_ready;

    // Single load point for the D registers
    assign load_resp = (state == RESPOND) || (state == ACCESS && !req_denied && seq_done);

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            tl_a_ready <= 1'b0;
            tl_d_valid <= 1'b0;
            seq_start  <= 1'b0;
        end else begin
            seq_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        tl_a_ready <= 1'b0;
                        seq_start  <= !denied;   // Denied requests never touch memory
                        state      <= ACCESS;
                    end else begin
                        tl_a_ready <= 1'b1;      // First cycle after reset too
                    end
                end
                ACCESS: begin
                    if (req_denied) begin
                        state <= RESPOND;        // Gives the two-cycle error latency
                    end else if (seq_done) begin
                        tl_d_valid <= 1'b1;
                        state      <= RESPOND_WAIT;
                    end
                end
                RESPOND: begin
                    tl_d_valid <= 1'b1;
                    state      <= RESPOND_WAIT;
                end
                RESPOND_WAIT: begin
                    if (tl_d_ready) begin
                        tl_d_valid <= 1'b0;
                        tl_a_ready <= 1'b1;      // Reopen right after the handshake
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Request capture and response registers
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (req_denied) begin
            resp_opcode = tl_mem_pkg::OP_ACCESS_ACK_ERROR;
            resp_param  = tl_mem_pkg::PARAM_ERROR;
            resp_data   = '0;
        end else if (seq_write) begin
            resp_opcode = tl_mem_pkg::OP_ACCESS_ACK;
            resp_param  = tl_mem_pkg::PARAM_OK;
            resp_data   = '0;
        end else begin
            resp_opcode = tl_mem_pkg::OP_ACCESS_ACK_DATA;
            resp_param  = tl_mem_pkg::PARAM_OK;
            resp_data   = seq_rdata;                 // Valid while seq_done is high
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            seq_addr   <= tl_a_address[tl_mem_pkg::MEM_ADDR_WIDTH-1:0];
            seq_size   <= tl_a_size;
            seq_write  <= (tl_a_opcode == tl_mem_pkg::OP_PUT_FULL_DATA);
            seq_wdata  <= tl_a_data;
            req_source <= tl_a_source;
            req_denied <= denied;
        end
        if (load_resp) begin
            tl_d_opcode <= resp_opcode;
            tl_d_param  <= resp_param;
            tl_d_size   <= seq_size;                 // Echo of the request
            tl_d_source <= req_source;
            tl_d_data   <= resp_data;
            tl_d_denied <= req_denied;
        end
    end

    ////////////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////////////

    a_no_accept_during_resp: assert property (@(posedge clk) disable iff (reset)
        accept |-> !tl_d_valid);

    a_d_stable: assert property (@(posedge clk) disable iff (reset)
        (tl_d_valid && !tl_d_ready) |=>
            $stable({tl_d_valid, tl_d_opcode, tl_d_param, tl_d_size,
                     tl_d_source, tl_d_data, tl_d_denied}));

endmodule

//--- source/tl_memory.sv
/*
 * TileLink-UL memory slave top level, 1 KiB of byte storage on a 32-bit bus.
 * Wires the access check, the controller and the byte sequencer together.
 */
`timescale 1ns/1ps

module tl_memory (
    input  logic                    clk,
    input  logic                    reset,

    // A channel
    input  logic                    tl_a_valid,
    output logic                    tl_a_ready,
    input  tl_mem_pkg::opcode_t     tl_a_opcode,
    input  tl_mem_pkg::size_t       tl_a_size,
    input  tl_mem_pkg::source_t     tl_a_source,
    input  tl_mem_pkg::addr_t       tl_a_address,
    input  tl_mem_pkg::mask_t       tl_a_mask,
    input  tl_mem_pkg::data_t       tl_a_data,

    // D channel
    output logic                    tl_d_valid,
    input  logic                    tl_d_ready,
    output tl_mem_pkg::opcode_t     tl_d_opcode,
    output tl_mem_pkg::d_param_t    tl_d_param,
    output tl_mem_pkg::size_t       tl_d_size,
    output tl_mem_pkg::source_t     tl_d_source,
    output tl_mem_pkg::data_t       tl_d_data,
    output logic                    tl_d_denied
);

    logic                                    denied;     // Live check of the A fields
    logic                                    seq_start;
    logic                                    seq_write;
    logic [tl_mem_pkg::MEM_ADDR_WIDTH-1:0]   seq_addr;
    tl_mem_pkg::size_t                       seq_size;
    tl_mem_pkg::data_t                       seq_wdata;
    logic                                    seq_done;
    tl_mem_pkg::data_t                       seq_rdata;

    tl_access_check u_check (
        .opcode  (tl_a_opcode),
        .size    (tl_a_size),
        .address (tl_a_address),
        .mask    (tl_a_mask),
        .denied  (denied)
    );

    tl_mem_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .tl_a_valid   (tl_a_valid),
        .tl_a_ready   (tl_a_ready),
        .tl_a_opcode  (tl_a_opcode),
        .tl_a_size    (tl_a_size),
        .tl_a_source  (tl_a_source),
        .tl_a_address (tl_a_address),
        .tl_a_data    (tl_a_data),
        .tl_d_valid   (tl_d_valid),
        .tl_d_ready   (tl_d_ready),
        .tl_d_opcode  (tl_d_opcode),
        .tl_d_param   (tl_d_param),
        .tl_d_size    (tl_d_size),
        .tl_d_source  (tl_d_source),
        .tl_d_data    (tl_d_data),
        .tl_d_denied  (tl_d_denied),
        .denied       (denied),
        .seq_start    (seq_start),
        .seq_write    (seq_write),
        .seq_addr     (seq_addr),
        .seq_size     (seq_size),
        .seq_wdata    (seq_wdata),
        .seq_done     (seq_done),
        .seq_rdata    (seq_rdata)
    );

    // One byte per cycle behind the controller
    byte_sequencer u_seq (
        .clk   (clk),
        .reset (reset),
        .start (seq_start),
        .write (seq_write),
        .addr  (seq_addr),
        .size  (seq_size),
        .wdata (seq_wdata),
        .done  (seq_done),
        .rdata (seq_rdata)
    );

endmodule

//--- test/tb_ref_model.svh
/*
 * Byte-array reference model, expected-response function and compare tasks.
 * Included inside the testbench module after its counters are declared.
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    tl_mem_pkg::opcode_t  opcode;
    tl_mem_pkg::d_param_t param;
    tl_mem_pkg::size_t    size;
    tl_mem_pkg::source_t  source;
    tl_mem_pkg::data_t    data;
    logic                 denied;
} resp_t;

logic [7:0] model_mem [tl_mem_pkg::MEM_BYTES];  // Mirror of the slave storage

// Initial contents, every address bit takes part
function automatic logic [7:0] fill_byte(int a);
    return 8'(a) ^ 8'(a >> 2) ^ 8'h5a;
endfunction

// Aligned group of 2^size ones anywhere on the bus
function automatic logic mask_legal(tl_mem_pkg::mask_t mask, tl_mem_pkg::size_t size);
    int         nbytes;
    int         off;
    logic [3:0] group;
    logic       ok;
    nbytes = 1 << size;
    group  = 4'((1 << nbytes) - 1);
    ok     = 1'b0;
    for (off = 0; off < 4; off += nbytes) begin
        if (mask == 4'(group << off))
            ok = 1'b1;
    end
    return ok;
endfunction

// Expected D response; a legal write also updates the model
function automatic resp_t predict(tl_mem_pkg::opcode_t opcode, tl_mem_pkg::size_t size,
                                  tl_mem_pkg::source_t source, tl_mem_pkg::addr_t address,
                                  tl_mem_pkg::mask_t mask, tl_mem_pkg::data_t data);
    resp_t       r;
    logic [63:0] last;
    int          nbytes;
    int          i;
    logic        ok;
    nbytes   = 1 << size;
    last     = 64'(address) + 64'(nbytes) - 64'd1;   // No wrap for high addresses
    ok       = (opcode == tl_mem_pkg::OP_GET || opcode == tl_mem_pkg::OP_PUT_FULL_DATA) &&
               (size <= 3'(tl_mem_pkg::MAX_SIZE)) && (last < 64'(tl_mem_pkg::MEM_BYTES));
    if (ok && opcode == tl_mem_pkg::OP_PUT_FULL_DATA)
        ok = mask_legal(mask, size);
    r.size   = size;
    r.source = source;
    r.data   = '0;
    r.denied = !ok;
    if (!ok) begin
        r.opcode = tl_mem_pkg::OP_ACCESS_ACK_ERROR;
        r.param  = tl_mem_pkg::PARAM_ERROR;
    end else if (opcode == tl_mem_pkg::OP_GET) begin
        r.opcode = tl_mem_pkg::OP_ACCESS_ACK_DATA;
        r.param  = tl_mem_pkg::PARAM_OK;
        for (i = 0; i < nbytes; i++)
            r.data[8*i +: 8] = model_mem[int'(address) + i];  // Zero-extended
    end else begin
        r.opcode = tl_mem_pkg::OP_ACCESS_ACK;
        r.param  = tl_mem_pkg::PARAM_OK;
        for (i = 0; i < nbytes; i++)
            model_mem[int'(address) + i] = data[8*i +: 8];   // Low lanes
    end
    return r;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic report_mismatch(string field, string exp_str, string act_str);
    error_count++;
    $display("Fail %s %s: expected %s, actual %s", test_name, field, exp_str, act_str);
endtask

task automatic compare_data(string field, tl_mem_pkg::data_t exp, tl_mem_pkg::data_t act);
    check_count++;
    if (act !== exp)
        report_mismatch(field, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic compare_opcode(string field, tl_mem_pkg::opcode_t exp,
                              tl_mem_pkg::opcode_t act);
    check_count++;
    if (act !== exp)
        report_mismatch(field, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic compare_param(string field, tl_mem_pkg::d_param_t exp,
                             tl_mem_pkg::d_param_t act);
    check_count++;
    if (act !== exp)
        report_mismatch(field, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic compare_size(string field, tl_mem_pkg::size_t exp, tl_mem_pkg::size_t act);
    check_count++;
    if (act !== exp)
        report_mismatch(field, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic compare_source(string field, tl_mem_pkg::source_t exp,
                              tl_mem_pkg::source_t act);
    check_count++;
    if (act !== exp)
        report_mismatch(field, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic compare_flag(string field, logic exp, logic act);
    check_count++;
    if (act !== exp)
        report_mismatch(field, $sformatf("%b", exp), $sformatf("%b", act));
endtask

`endif

//--- test/tb_tl_memory.sv
/*
 * Testbench for the TileLink-UL memory slave. Directed and random requests
 * are checked against a byte-array model, with and without D back-pressure.
 */
`timescale 1ns/1ps

module tb_tl_memory;

    localparam int CLK_PERIOD = 100;        // ns
    localparam int REQ_BOUND  = 40;         // Cycles allowed per request
    localparam int N_FILL     = tl_mem_pkg::MEM_BYTES / 4;
    localparam int N_DIRECTED = 30;         // Upper bound over the directed tests
    localparam int N_STALL    = 40;
    localparam int N_RANDOM   = 200;
    localparam int N_REQUESTS = N_FILL + N_DIRECTED + N_STALL + N_RANDOM;

    localparam tl_mem_pkg::opcode_t GET = tl_mem_pkg::OP_GET;
    localparam tl_mem_pkg::opcode_t PUT = tl_mem_pkg::OP_PUT_FULL_DATA;

    logic                   clk;
    logic                   reset;
    logic                   tl_a_valid;
    logic                   tl_a_ready;
    tl_mem_pkg::opcode_t    tl_a_opcode;
    tl_mem_pkg::size_t      tl_a_size;
    tl_mem_pkg::source_t    tl_a_source;
    tl_mem_pkg::addr_t      tl_a_address;
    tl_mem_pkg::mask_t      tl_a_mask;
    tl_mem_pkg::data_t      tl_a_data;
    logic                   tl_d_valid;
    logic                   tl_d_ready;
    tl_mem_pkg::opcode_t    tl_d_opcode;
    tl_mem_pkg::d_param_t   tl_d_param;
    tl_mem_pkg::size_t      tl_d_size;
    tl_mem_pkg::source_t    tl_d_source;
    tl_mem_pkg::data_t      tl_d_data;
    logic                   tl_d_denied;

    string                  test_name = "reset";
    int                     error_count = 0;
    int                     check_count = 0;
    int                     test_count = 0;
    int                     test_errors_start = 0;
    int                     seed = 32'h65c9_c996;        // Stimulus stream
    int                     stall_seed = 32'h65c9_c996;  // D back-pressure stream
    bit                     stall_mode = 1'b0;
    tl_mem_pkg::source_t    next_source = '0;

    `include "tb_ref_model.svh"

    resp_t                  expected_q [$];  // Oldest outstanding request first

    tl_memory u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (REQ_BOUND * N_REQUESTS + 10));
        $display("Timeout: test %s did not finish within %0d cycles", test_name,
                 REQ_BOUND * N_REQUESTS + 10);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // D-channel monitor, also drives tl_d_ready
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        resp_t exp;
        tl_d_ready = !stall_mode || (($random(stall_seed) & 3) == 0);  // Mostly low in stall
        if (!reset && tl_d_valid && tl_a_ready) begin
            error_count++;
            $display("Error in %s: tl_a_ready is high while a response waits", test_name);
        end
        if (!reset && tl_d_valid && tl_d_ready) begin   // Handshake at next rising edge
            if (expected_q.size() == 0) begin
                error_count++;
                $display("Error in %s: response with no request outstanding", test_name);
            end else begin
                exp = expected_q.pop_front();
                compare_opcode("opcode", exp.opcode, tl_d_opcode);
                compare_param("param", exp.param, tl_d_param);
                compare_size("size", exp.size, tl_d_size);
                compare_source("source", exp.source, tl_d_source);
                compare_data("data", exp.data, tl_d_data);
                compare_flag("denied", exp.denied, tl_d_denied);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // One A request, held until accepted
    task automatic send(tl_mem_pkg::opcode_t opcode, tl_mem_pkg::size_t size,
                        tl_mem_pkg::addr_t address, tl_mem_pkg::mask_t mask,
                        tl_mem_pkg::data_t data);
        @(negedge clk);
        tl_a_valid   = 1'b1;
        tl_a_opcode  = opcode;
        tl_a_size    = size;
        tl_a_source  = next_source;
        tl_a_address = address;
        tl_a_mask    = mask;
        tl_a_data    = data;
        while (!tl_a_ready)
            @(negedge clk);
        expected_q.push_back(predict(opcode, size, next_source, address, mask, data));
        next_source++;
        @(negedge clk);                  // Accepted at the edge in between
        tl_a_valid = 1'b0;
    endtask

    task automatic send_random();
        logic [31:0]       choice;
        tl_mem_pkg::addr_t address;
        tl_mem_pkg::data_t data;
        tl_mem_pkg::opcode_t opcode;
        tl_mem_pkg::size_t size;
        tl_mem_pkg::mask_t mask;
        int                nbytes;
        int                lane;
        choice  = $random(seed);
        address = $random(seed);
        data    = $random(seed);
        opcode  = choice[0] ? GET : PUT;
        if (choice[4:1] == 4'd0)
            opcode = choice[7:5];                    // Rare illegal opcode
        size = 3'(choice[9:8] % 2'd3);
        if (choice[13:10] == 4'd0)
            size = 3'd3;
        if (choice[17:14] != 4'd0)
            address = address & 32'h3ff;             // Mostly inside the array
        nbytes = 1 << size;
        lane   = (int'(choice[19:18]) / nbytes) * nbytes;
        mask   = 4'(((1 << nbytes) - 1) << lane);
        if (choice[23:20] == 4'd0)
            mask = choice[27:24];                    // Occasional junk mask
        send(opcode, size, address, mask, data);
    endtask

    task automatic begin_test(string name);
        test_name         = name;
        test_errors_start = error_count;
        test_count++;
    endtask

    task automatic end_test(int requests);
        while (expected_q.size() != 0)
            @(posedge clk);
        $display("Test %-16s %4d requests, %0d errors", test_name, requests,
                 error_count - test_errors_start);
    endtask

    task automatic fill_memory();
        int a;
        begin_test("fill");
        for (a = 0; a < tl_mem_pkg::MEM_BYTES; a += 4)
            send(PUT, 3'd2, 32'(a), 4'hf,
                 {fill_byte(a + 3), fill_byte(a + 2), fill_byte(a + 1), fill_byte(a)});
        end_test(N_FILL);
    endtask

    task automatic write_read_sizes();
        tl_mem_pkg::addr_t address;
        int                s;
        begin_test("write_read");
        for (s = 0; s <= tl_mem_pkg::MAX_SIZE; s++) begin
            address = 32'h101 + 32'(s * 'h101);      // Unaligned on purpose
            send(PUT, 3'(s), address, 4'((1 << (1 << s)) - 1), $random(seed));
            send(GET, 3'(s), address, 4'h0, 32'h0);
        end
        end_test(6);
    endtask

    task automatic range_checks();
        begin_test("range");
        send(GET, 3'd2, 32'd1021, 4'hf, 32'h0);          // Last byte at 1024
        send(PUT, 3'd2, 32'd1021, 4'hf, 32'h1234_5678);
        send(GET, 3'd2, 32'd1020, 4'hf, 32'h0);          // Top word, legal
        send(GET, 3'd1, 32'd1023, 4'h3, 32'h0);
        send(PUT, 3'd0, 32'd1023, 4'b1000, 32'h0000_00a5);
        send(GET, 3'd0, 32'd1023, 4'h0, 32'h0);
        send(GET, 3'd0, 32'h0000_0400, 4'h0, 32'h0);
        send(GET, 3'd0, 32'h8000_0010, 4'h0, 32'h0);     // Upper bits set
        end_test(8);
    endtask

    task automatic mask_checks();
        begin_test("mask");
        send(PUT, 3'd2, 32'h40, 4'b0111, 32'hdead_beef);  // Too few ones
        send(PUT, 3'd1, 32'h40, 4'b0110, 32'hdead_beef);  // Misaligned pair
        send(PUT, 3'd0, 32'h40, 4'b0011, 32'hdead_beef);  // Too many ones
        send(PUT, 3'd1, 32'h40, 4'b1000, 32'hdead_beef);
        send(GET, 3'd2, 32'h40, 4'h0, 32'h0);             // Still the fill pattern
        end_test(5);
    endtask

    task automatic illegal_requests();
        begin_test("illegal");
        send(GET, 3'd3, 32'h0, 4'hf, 32'h0);
        send(PUT, 3'd3, 32'h0, 4'hf, 32'hffff_ffff);
        send(3'd1, 3'd2, 32'h0, 4'hf, 32'h0bad_0bad);     // Partial put, not kept
        send(3'd5, 3'd0, 32'h8, 4'h1, 32'h0);
        send(3'd6, 3'd1, 32'h10, 4'h3, 32'h0);
        end_test(5);
    endtask

    task automatic random_mix(string name, int count, bit stall);
        int n;
        begin_test(name);
        stall_mode = stall;
        for (n = 0; n < count; n++)
            send_random();
        end_test(count);
        stall_mode = 1'b0;
    endtask

    initial begin
        reset        = 1'b1;
        tl_a_valid   = 1'b0;
        tl_a_opcode  = '0;
        tl_a_size    = '0;
        tl_a_source  = '0;
        tl_a_address = '0;
        tl_a_mask    = '0;
        tl_a_data    = '0;
        tl_d_ready   = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fill_memory();
        write_read_sizes();
        range_checks();
        mask_checks();
        illegal_requests();
        random_mix("back_pressure", N_STALL, 1'b1);
        random_mix("random", N_RANDOM, 1'b0);

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- build.f
source/tl_mem_pkg.sv
source/tl_access_check.sv
source/byte_sequencer.sv
source/tl_mem_ctrl.sv
source/tl_memory.sv
+incdir+test
test/tb_tl_memory.sv

//--- Makefile
# Verilator build and run of the TileLink-UL memory slave testbench

VERILATOR ?= verilator
TOP       ?= tb_tl_memory
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
